/* common/spart_consts.svh */
// Serial port sizing constants shared by queues, registers and line engine
`ifndef SPART_CONSTS_SVH
`define SPART_CONSTS_SVH

// Byte path
`define SPART_DATA_W 8          // Bits per serial byte

// Queues
`define SPART_Q_DEPTH 8         // Entries per queue, power of two
`define SPART_CNT_W 4           // Level 0..8 needs one extra bit

// Bit period
`define SPART_DIV_W 13          // Divisor register width
`define SPART_DIV_RESET 13'h1B2 // Divisor after reset

// Period is divisor + 1 clocks
// Divisor high byte carries only DIV_W - DATA_W bits

`endif

/* common/spart_bus_pkg.sv */
// Processor bus types for the serial port register file
`include "spart_consts.svh"

package spart_bus_pkg;

    // Register map on the 2-bit address
    typedef enum logic [1:0] {
        REG_DATA   = 2'd0,  // Tx push on write, rx pop on read
        REG_STATUS = 2'd1,  // Tx free slots and rx level
        REG_DIV_LO = 2'd2,  // Divisor bits 7..0
        REG_DIV_HI = 2'd3   // Divisor upper bits
    } reg_addr_e;

    // Bit period minus one
    typedef logic [`SPART_DIV_W-1:0] divisor_t;

endpackage

/* common/spart_line_pkg.sv */
// Serial line engine types for the 8N1 frame sequencing
`include "spart_consts.svh"

package spart_line_pkg;

    // Frame phase, shared by both directions
    typedef enum logic [1:0] {
        LINE_IDLE  = 2'd0,  // Line high, waiting
        LINE_START = 2'd1,  // Start bit period
        LINE_DATA  = 2'd2,  // Eight data bits
        LINE_STOP  = 2'd3   // Stop bit period
    } line_state_e;

    // Which data bit is on the line
    typedef logic [$clog2(`SPART_DATA_W)-1:0] bit_idx_t;

endpackage

/* common/byte_queue_if.sv */
// Byte queue interface bundling push, pop, head data and fill status
`timescale 1ns/10ps
`include "spart_consts.svh"

interface byte_queue_if;

    logic                    push;       // Producer strobe
    logic [`SPART_DATA_W-1:0] push_data;
    logic                    pop;        // Consumer strobe
    logic [`SPART_DATA_W-1:0] pop_data;  // Head byte, valid when not empty
    logic                    full;
    logic                    empty;
    logic [`SPART_CNT_W-1:0] level;      // Entries held

    // Storage side
    modport queue (input push, push_data, pop, output pop_data, full, empty, level);

    // Writer side
    modport producer (output push, push_data, input full, level);

    // Reader side
    modport consumer (output pop, input pop_data, empty, level);

endinterface

/* design/byte_queue.sv */
// Circular byte queue with full, empty and level flags from a fill counter
`timescale 1ns/10ps
`include "spart_consts.svh"

module byte_queue (
    input logic      clk,
    input logic      rst_n,
    byte_queue_if.queue q
);

    logic [`SPART_DATA_W-1:0]          mem [`SPART_Q_DEPTH];
    logic [$clog2(`SPART_Q_DEPTH)-1:0] wr_ptr;   // Next free slot
    logic [$clog2(`SPART_Q_DEPTH)-1:0] rd_ptr;   // Head slot
    logic [`SPART_CNT_W-1:0]           count;
    logic                              do_push;
    logic                              do_pop;

    // Push when full and pop when empty are dropped
    assign do_push = q.push && !q.full;
    assign do_pop  = q.pop && !q.empty;

    ////////////////////
    // Storage
    ////////////////////
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= q.push_data;
        end
    end

    ////////////////////
    // Pointers and level
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves level alone
            count <= count + `SPART_CNT_W'(do_push) - `SPART_CNT_W'(do_pop);
        end
    end

    assign q.pop_data = mem[rd_ptr];          // Head seen without a pop
    assign q.full     = (count == `SPART_Q_DEPTH);
    assign q.empty    = (count == '0);
    assign q.level    = count;

endmodule

/* design/spart_regs.sv */
// Register file decoding the chip-select bus into queue strobes and divisor
`timescale 1ns/10ps
`include "spart_consts.svh"

module spart_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cs_n,     // Access strobe, active low
    input  logic                     rw_n,     // High reads, low writes
    input  logic [1:0]               addr,
    input  logic [`SPART_DATA_W-1:0] wdata,
    output logic [`SPART_DATA_W-1:0] rdata,
    output spart_bus_pkg::divisor_t  divisor,
    byte_queue_if.producer           tx_q,
    byte_queue_if.consumer           rx_q
);

    spart_bus_pkg::reg_addr_e reg_sel;
    logic                     rd;
    logic                     wr;
    logic [`SPART_CNT_W-1:0]  tx_free;    // Open tx slots

    assign reg_sel = spart_bus_pkg::reg_addr_e'(addr);
    assign rd      = !cs_n && rw_n;
    assign wr      = !cs_n && !rw_n;
    assign tx_free = `SPART_CNT_W'(`SPART_Q_DEPTH) - tx_q.level;

    // Data register hits move bytes in and out of the queues
    assign tx_q.push      = wr && (reg_sel == spart_bus_pkg::REG_DATA);
    assign tx_q.push_data = wdata;
    assign rx_q.pop       = rd && (reg_sel == spart_bus_pkg::REG_DATA); // Pops on the read edge

    ////////////////////
    // Divisor
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            divisor <= `SPART_DIV_RESET;
        end else if (wr && (reg_sel == spart_bus_pkg::REG_DIV_LO)) begin
            divisor[`SPART_DATA_W-1:0] <= wdata;
        end else if (wr && (reg_sel == spart_bus_pkg::REG_DIV_HI)) begin
            // Only the bits that exist above the low byte
            divisor[`SPART_DIV_W-1:`SPART_DATA_W] <= wdata[`SPART_DIV_W-`SPART_DATA_W-1:0];
        end
    end

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        rdata = '0;                          // Idle bus reads zero
        if (rd) begin
            case (reg_sel)
                spart_bus_pkg::REG_DATA:   rdata = rx_q.pop_data;
                spart_bus_pkg::REG_STATUS: rdata = {tx_free, rx_q.level};
                spart_bus_pkg::REG_DIV_LO: rdata = divisor[`SPART_DATA_W-1:0];
                spart_bus_pkg::REG_DIV_HI: begin
                    // Zero filled above the divisor top bit
                    rdata = `SPART_DATA_W'(divisor[`SPART_DIV_W-1:`SPART_DATA_W]);
                end
                default:                   rdata = '0;
            endcase
        end
    end

endmodule

/* line/baud_timer.sv */
// Bit period down-counter with restart and half-period start
`timescale 1ns/10ps
`include "spart_consts.svh"

module baud_timer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`SPART_DIV_W-1:0] divisor,   // Period minus one
    input  logic                   restart,   // Reload now
    input  logic                   half,      // Reload with half period
    output logic                   tick
);

    logic [`SPART_DIV_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (restart) begin
            cnt <= half ? (divisor >> 1) : divisor;
        end else if (cnt == '0) begin
            cnt <= divisor;               // Free runs between restarts
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // One clock at zero, divisor + 1 clocks apart
    assign tick = (cnt == '0);

endmodule

/* line/line_shift.sv */
// Serial line datapath with tx and rx shift registers and bit counters
`timescale 1ns/10ps
`include "spart_consts.svh"

module line_shift (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           rx,
    input  logic           tx_load,
    input  logic           tx_shift,
    input  logic           rx_sample,
    input  logic           rx_done,
    input  logic           tx_busy,
    byte_queue_if.consumer tx_q,     // Head byte only, pop comes from the FSM
    byte_queue_if.producer rx_q,
    output logic           tx,
    output logic           tx_last_bit,
    output logic           rx_last_bit
);

    logic [`SPART_DATA_W:0]   tx_sr;    // Data above the start bit
    logic [`SPART_DATA_W-1:0] rx_sr;
    spart_line_pkg::bit_idx_t tx_cnt;
    spart_line_pkg::bit_idx_t rx_cnt;

    // Shifters
    always_ff @(posedge clk) begin
        if (tx_load) begin
            tx_sr <= {tx_q.pop_data, 1'b0};
        end else if (tx_shift) begin
            tx_sr <= {1'b1, tx_sr[`SPART_DATA_W:1]};   // Ones fill in as stop bit
        end
        if (rx_sample) begin
            rx_sr <= {rx, rx_sr[`SPART_DATA_W-1:1]};   // LSB lands at bit 0
        end
    end

    // Counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_cnt <= '1;
            rx_cnt <= '0;
        end else begin
            // Starts at all ones so the start bit shift wraps it to bit 0
            if (tx_load) begin
                tx_cnt <= '1;
            end else if (tx_shift) begin
                tx_cnt <= tx_cnt + 1'b1;
            end
            if (rx_sample) begin
                rx_cnt <= rx_cnt + 1'b1;    // Wraps back to 0 after bit 7
            end
        end
    end

    assign tx_last_bit   = &tx_cnt;
    assign rx_last_bit   = &rx_cnt;
    assign tx            = tx_busy ? tx_sr[0] : 1'b1;
    assign rx_q.push     = rx_done;          // Queue drops it when full
    assign rx_q.push_data = rx_sr;

endmodule

/* line/line_fsm.sv */
// Serial line sequencer running the 8N1 transmit and receive frame FSMs
`timescale 1ns/10ps

module line_fsm (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           rx,
    input  logic           tx_tick,      // End of a tx bit period
    input  logic           rx_tick,      // Mid-bit sample point
    input  logic           tx_last_bit,
    input  logic           rx_last_bit,
    byte_queue_if.consumer tx_q,
    output logic           tx_load,
    output logic           tx_shift,
    output logic           tx_busy,
    output logic           rx_sample,
    output logic           rx_done,
    output logic           tx_restart,
    output logic           rx_restart,
    output logic           rx_half
);

    spart_line_pkg::line_state_e tx_state, tx_next;
    spart_line_pkg::line_state_e rx_state, rx_next;
    logic rx_meta, rx_sync, rx_prev;   // Synchronizer and edge history
    logic rx_fall;

    ////////////////////
    // State and rx sync
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_state <= spart_line_pkg::LINE_IDLE;
            rx_state <= spart_line_pkg::LINE_IDLE;
            rx_meta  <= 1'b1;                  // Line idles high
            rx_sync  <= 1'b1;
            rx_prev  <= 1'b1;
        end else begin
            tx_state <= tx_next;
            rx_state <= rx_next;
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_prev  <= rx_sync;
        end
    end

    assign rx_fall = rx_prev && !rx_sync;

    // Tx frame sequencing
    always_comb begin
        tx_next = tx_state;
        case (tx_state)
            spart_line_pkg::LINE_IDLE:  if (!tx_q.empty) tx_next = spart_line_pkg::LINE_START;
            spart_line_pkg::LINE_START: if (tx_tick) tx_next = spart_line_pkg::LINE_DATA;
            spart_line_pkg::LINE_DATA:  if (tx_tick && tx_last_bit) tx_next = spart_line_pkg::LINE_STOP;
            spart_line_pkg::LINE_STOP:  if (tx_tick) tx_next = spart_line_pkg::LINE_IDLE;
            default:                    tx_next = spart_line_pkg::LINE_IDLE;
        endcase
    end

    // Rx frame sequencing, false start falls back to idle
    always_comb begin
        rx_next = rx_state;
        case (rx_state)
            spart_line_pkg::LINE_IDLE:  if (rx_fall) rx_next = spart_line_pkg::LINE_START;
            spart_line_pkg::LINE_START: begin
                if (rx_tick) begin
                    rx_next = rx_sync ? spart_line_pkg::LINE_IDLE : spart_line_pkg::LINE_DATA;
                end
            end
            spart_line_pkg::LINE_DATA:  if (rx_tick && rx_last_bit) rx_next = spart_line_pkg::LINE_STOP;
            spart_line_pkg::LINE_STOP:  if (rx_tick) rx_next = spart_line_pkg::LINE_IDLE;
            default:                    rx_next = spart_line_pkg::LINE_IDLE;
        endcase
    end

    assign tx_busy    = (tx_state != spart_line_pkg::LINE_IDLE);
    assign tx_load    = !tx_busy && !tx_q.empty;    // Load and pop together
    assign tx_q.pop   = tx_load;
    assign tx_shift   = tx_tick && ((tx_state == spart_line_pkg::LINE_START) ||
                                    (tx_state == spart_line_pkg::LINE_DATA));
    assign tx_restart = (tx_next != tx_state);      // Fresh period on state entry

    assign rx_sample  = rx_tick && (rx_state == spart_line_pkg::LINE_DATA);
    assign rx_done    = rx_tick && (rx_state == spart_line_pkg::LINE_STOP) && rx_sync; // Bad stop drops byte
    assign rx_restart = (rx_next != rx_state);
    assign rx_half    = (rx_state == spart_line_pkg::LINE_IDLE); // Half wait to start bit middle

endmodule

/* design/spart.sv */
// Serial port top joining registers, byte queues and the 8N1 line engine
`timescale 1ns/10ps
`include "spart_consts.svh"

module spart (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cs_n,
    input  logic                     rw_n,
    input  logic [1:0]               addr,
    input  logic [`SPART_DATA_W-1:0] wdata,
    input  logic                     rx,
    output logic [`SPART_DATA_W-1:0] rdata,
    output logic                     tx,
    output logic                     tx_q_full,
    output logic                     rx_q_empty
);

    byte_queue_if tx_q ();
    byte_queue_if rx_q ();

    spart_bus_pkg::divisor_t divisor;    // Shared by both timers
    logic tx_load, tx_shift, tx_busy;
    logic rx_sample, rx_done;
    logic tx_restart, rx_restart, rx_half;
    logic tx_tick, rx_tick;
    logic tx_last_bit, rx_last_bit;

    assign tx_q_full  = tx_q.full;
    assign rx_q_empty = rx_q.empty;

    ////////////////////
    // Bus side
    ////////////////////
    spart_regs u_regs (
        .clk(clk), .rst_n(rst_n), .cs_n(cs_n), .rw_n(rw_n),
        .addr(addr), .wdata(wdata), .rdata(rdata), .divisor(divisor),
        .tx_q(tx_q.producer), .rx_q(rx_q.consumer)
    );

    byte_queue u_tx_queue (.clk(clk), .rst_n(rst_n), .q(tx_q.queue));
    byte_queue u_rx_queue (.clk(clk), .rst_n(rst_n), .q(rx_q.queue));

    ////////////////////
    // Line side
    ////////////////////
    line_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .rx(rx),
        .tx_tick(tx_tick), .rx_tick(rx_tick),
        .tx_last_bit(tx_last_bit), .rx_last_bit(rx_last_bit),
        .tx_q(tx_q.consumer),
        .tx_load(tx_load), .tx_shift(tx_shift), .tx_busy(tx_busy),
        .rx_sample(rx_sample), .rx_done(rx_done),
        .tx_restart(tx_restart), .rx_restart(rx_restart), .rx_half(rx_half)
    );

    // Tx always runs whole periods
    baud_timer u_tx_timer (
        .clk(clk), .rst_n(rst_n), .divisor(divisor),
        .restart(tx_restart), .half(1'b0), .tick(tx_tick)
    );

    baud_timer u_rx_timer (
        .clk(clk), .rst_n(rst_n), .divisor(divisor),
        .restart(rx_restart), .half(rx_half), .tick(rx_tick)
    );

    line_shift u_shift (
        .clk(clk), .rst_n(rst_n), .rx(rx),
        .tx_load(tx_load), .tx_shift(tx_shift),
        .rx_sample(rx_sample), .rx_done(rx_done), .tx_busy(tx_busy),
        .tx_q(tx_q.consumer), .rx_q(rx_q.producer),
        .tx(tx), .tx_last_bit(tx_last_bit), .rx_last_bit(rx_last_bit)
    );

endmodule

/* bench/spart_tb.sv */
// Loopback testbench for the serial port with reference model and frame monitor
`timescale 1ns/10ps
`include "spart_consts.svh"

module spart_tb;

    localparam int TEST_DIV   = 15;                  // 16 clocks per bit
    localparam int FRAMES     = 32;                  // 1 + 1 + 20 + 10 frames
    localparam int MAX_CYCLES = FRAMES * 10 * (TEST_DIV + 1) + 2000;
    localparam int QUIET      = 11 * (TEST_DIV + 1); // Longer than any high run in a frame

    logic        clk, rst_n, cs_n, rw_n;
    logic [1:0]  addr;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        tx_q_full, rx_q_empty;
    wire         line;                               // tx looped back into rx
    logic [15:0] lfsr;
    logic [7:0]  ref_q[$];                           // Bytes on their way back
    int          errors = 0;
    int          checks = 0;
    int          tests_ok = 0;
    int          cycles = 0;

    spart dut (
        .clk(clk), .rst_n(rst_n), .cs_n(cs_n), .rw_n(rw_n), .addr(addr), .wdata(wdata),
        .rx(line), .rdata(rdata), .tx(line), .tx_q_full(tx_q_full), .rx_q_empty(rx_q_empty)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                      // 20 ns period
    end

    // Run budget in clocks
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Taps 16, 14, 13, 11
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);                  // One step per bit
            b    = {b[6:0], lfsr[0]};
        end
        return b;
    endfunction

    // Status is tx free slots over rx level
    function automatic logic [7:0] expected_status(input int tx_level, input int rx_level);
        return {4'(`SPART_Q_DEPTH - tx_level), 4'(rx_level)};
    endfunction

    // Line level for bit 0 start, 1..8 data, 9 stop
    function automatic logic frame_bit_level(input logic [7:0] data, input int idx);
        if (idx == 0) return 1'b0;
        if (idx == 9) return 1'b1;
        return data[idx-1];
    endfunction

    function automatic int bytes_kept(input int sent);
        return (sent > `SPART_Q_DEPTH) ? `SPART_Q_DEPTH : sent;   // Rx queue drops the rest
    endfunction

    function automatic logic [7:0] oldest_sent();
        return ref_q.pop_front();                    // Oldest byte comes back first
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %02h, got %02h", $time, name, exp, got);
        end
    endtask

    task automatic check_status(input string name, input logic [7:0] exp,
                                input logic [7:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %02h, got %02h", $time, name, exp, got);
        end
    endtask

    task automatic check_divisor(input string name, input spart_bus_pkg::divisor_t exp,
                                 input spart_bus_pkg::divisor_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %03h, got %03h", $time, name, exp, got);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    ////////////////////
    // Bus and line helpers
    ////////////////////
    task automatic bus_write(input spart_bus_pkg::reg_addr_e a, input logic [7:0] d);
        @(posedge clk);
        #2;
        cs_n  = 1'b0;
        rw_n  = 1'b0;
        addr  = a;
        wdata = d;
        @(posedge clk);                              // Write lands here
        #2;
        cs_n  = 1'b1;
        rw_n  = 1'b1;
    endtask

    task automatic bus_read(input spart_bus_pkg::reg_addr_e a, output logic [7:0] d);
        @(posedge clk);
        #2;
        cs_n = 1'b0;
        rw_n = 1'b1;
        addr = a;
        @(negedge clk);
        d = rdata;                                   // Mid-cycle, before the pop edge
        @(posedge clk);
        #2;
        cs_n = 1'b1;
    endtask

    task automatic wait_rx_ready();
        while (rx_q_empty) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_line_quiet();
        int high;
        high = 0;
        while (high < QUIET) begin
            @(posedge clk);
            #2;
            high = line ? high + 1 : 0;
        end
    endtask

    // Samples the middle of each bit after the start edge
    task automatic watch_frame(input logic [7:0] data);
        @(negedge line);
        repeat ((TEST_DIV + 1) / 2) @(posedge clk);
        for (int i = 0; i < 10; i++) begin
            if (i > 0) repeat (TEST_DIV + 1) @(posedge clk);
            @(negedge clk);
            check_flag($sformatf("tx bit %0d", i), frame_bit_level(data, i), line);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("Test %0d %s: passed", num, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", num, name, errors - errs_before);
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        logic [7:0] lo, hi, d;
        logic       full_seen;
        int         e, sent, got;
        $timeformat(-9, 1, " ns", 0);
        lfsr  = 16'd20801;
        rst_n = 1'b0;
        cs_n  = 1'b1;
        rw_n  = 1'b1;
        addr  = 2'd0;
        wdata = 8'h00;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        e = errors;                                  // Reset state
        check_flag("tx_q_full", 1'b0, tx_q_full);
        check_flag("rx_q_empty", 1'b1, rx_q_empty);
        check_flag("tx", 1'b1, line);
        bus_read(spart_bus_pkg::REG_STATUS, d);
        check_status("status", expected_status(0, 0), d);
        bus_read(spart_bus_pkg::REG_DIV_LO, lo);
        bus_read(spart_bus_pkg::REG_DIV_HI, hi);
        check_byte("div_hi", 8'(`SPART_DIV_RESET >> 8), hi);
        check_divisor("divisor", `SPART_DIV_RESET, spart_bus_pkg::divisor_t'({hi, lo}));
        report_test(1, "reset state", e);

        e = errors;                                  // Divisor readback
        bus_write(spart_bus_pkg::REG_DIV_LO, 8'(TEST_DIV));
        bus_write(spart_bus_pkg::REG_DIV_HI, 8'(TEST_DIV >> 8));
        bus_read(spart_bus_pkg::REG_DIV_LO, lo);
        bus_read(spart_bus_pkg::REG_DIV_HI, hi);
        check_byte("div_lo", 8'(TEST_DIV), lo);
        check_byte("div_hi", 8'h00, hi);
        check_divisor("divisor", spart_bus_pkg::divisor_t'(TEST_DIV),
                      spart_bus_pkg::divisor_t'({hi, lo}));
        report_test(2, "divisor write", e);

        e = errors;                                  // Frame on the wire
        ref_q.push_back(8'h4B);
        fork
            watch_frame(8'h4B);
            bus_write(spart_bus_pkg::REG_DATA, 8'h4B);
        join
        wait_rx_ready();
        bus_read(spart_bus_pkg::REG_DATA, d);
        check_byte("rdata", oldest_sent(), d);
        report_test(3, "frame format", e);

        e = errors;                                  // One byte round trip
        ref_q.push_back(8'hC3);
        bus_write(spart_bus_pkg::REG_DATA, 8'hC3);
        wait_rx_ready();
        bus_read(spart_bus_pkg::REG_DATA, d);
        check_byte("rdata", oldest_sent(), d);
        check_flag("rx_q_empty", 1'b1, rx_q_empty);
        report_test(4, "single loopback", e);

        e = errors;                                  // Reads take priority over writes
        sent = 0;
        got  = 0;
        while (got < 20) begin
            if (!rx_q_empty) begin
                bus_read(spart_bus_pkg::REG_DATA, d);
                check_byte("rdata", oldest_sent(), d);
                got++;
            end else if (sent < 20 && !tx_q_full) begin
                d = random_byte();
                ref_q.push_back(d);
                bus_write(spart_bus_pkg::REG_DATA, d);
                sent++;
            end else begin
                @(posedge clk);
                #2;
            end
        end
        report_test(5, "random burst", e);

        e = errors;                                  // Nothing read until the line is idle
        sent      = 0;
        full_seen = 1'b0;
        while (sent < 10) begin
            if (!tx_q_full) begin
                d = random_byte();
                ref_q.push_back(d);
                bus_write(spart_bus_pkg::REG_DATA, d);
                sent++;
            end else begin
                if (!full_seen) begin
                    // Full tx queue, first frame of this burst still on the wire
                    full_seen = 1'b1;
                    bus_read(spart_bus_pkg::REG_STATUS, d);
                    check_status("status", expected_status(`SPART_Q_DEPTH, 0), d);
                end
                @(posedge clk);
                #2;
            end
        end
        check_flag("tx_q_full seen", 1'b1, full_seen);
        wait_line_quiet();
        bus_read(spart_bus_pkg::REG_STATUS, d);
        check_status("status", expected_status(0, bytes_kept(sent)), d);
        for (int i = 0; i < bytes_kept(sent); i++) begin
            bus_read(spart_bus_pkg::REG_DATA, d);
            check_byte("rdata", oldest_sent(), d);
        end
        check_flag("rx_q_empty", 1'b1, rx_q_empty);
        ref_q.delete();                              // Overflow bytes never arrive
        report_test(6, "receive overflow", e);

        $display("Tests passed %0d of 6, checks %0d, errors %0d", tests_ok, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+common
common/spart_bus_pkg.sv
common/spart_line_pkg.sv
common/byte_queue_if.sv
design/byte_queue.sv
design/spart_regs.sv
line/baud_timer.sv
line/line_shift.sv
line/line_fsm.sv
design/spart.sv
bench/spart_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= spart_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps
PASS_MSG  ?= *** TEST PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
